/* hw/aa_map_pkg.sv */
// ----------------------------
// mailbox bridge address map
// LS region codes, SS address tags and the
// mailbox / interrupt register layout
// ----------------------------
package aa_map_pkg;

  // ----------------------------
  // mailbox
  // ----------------------------
  localparam int mbox_words = 8;

  // word index sits in address bits 4..2
  localparam int mbox_idx_lsb = 2;
  localparam int mbox_idx_msb = 4;
  typedef logic [mbox_idx_msb-mbox_idx_lsb:0] mbox_idx_t;

  // ----------------------------
  // LS side decode, addr[11:8]
  // ----------------------------
  localparam int ls_region_lsb = 8;
  localparam int ls_region_msb = 11;
  typedef logic [ls_region_msb-ls_region_lsb:0] ls_region_t;
  localparam ls_region_t ls_region_mbox = 4'h0;
  localparam ls_region_t ls_region_reg  = 4'h1;

  // ----------------------------
  // SS side decode, addr[27:8]
  // ----------------------------
  localparam int ss_tag_lsb = 8;
  localparam int ss_tag_msb = 27;
  typedef logic [ss_tag_msb-ss_tag_lsb:0] ss_tag_t;
  localparam ss_tag_t ss_tag_mbox = 20'h00020;
  localparam ss_tag_t ss_tag_reg  = 20'h00021;

  // clear picks intr_enable (offset 0), set picks intr_status (offset 4)
  localparam int reg_sel_bit = 2;

endpackage

/* hw/aa_bus_pkg.sv */
// ----------------------------
// mailbox bridge bus types
// stream beat, tuser packet codes, latched LS
// request and the register write port
// ----------------------------
package aa_bus_pkg;

  // mailbox index type for the register write port
  import aa_map_pkg::*;

  // stream word, also the AXI-Lite data width
  typedef logic [31:0] axis_data_t;

  // AXI-Lite slave address
  typedef logic [14:0] ls_addr_t;

  // tuser codes carried on every beat
  typedef enum logic [1:0] {
    pkt_stream   = 2'd0,
    pkt_write    = 2'd1,
    pkt_read_req = 2'd2,
    pkt_read_rsp = 2'd3
  } pkt_e;

  typedef struct packed {
    axis_data_t tdata;
    pkt_e       tuser;
  } axis_beat_t;

  // one LS request as held during a transaction
  typedef struct packed {
    ls_addr_t   addr;
    axis_data_t wdata;
    logic       wr;
  } ls_req_t;

  // write port into the register block
  typedef struct packed {
    logic       valid;
    logic       is_reg;
    mbox_idx_t  idx;
    axis_data_t data;
  } reg_wr_t;

  // which beat the stream master is driving
  typedef enum logic [1:0] {
    tx_none,
    tx_addr,
    tx_data,
    tx_rd_req
  } tx_sel_e;

endpackage

/* hw/aa_ctrl.sv */
// ----------------------------
// mailbox bridge controller
// single FSM for LS and SS transactions, drives
// every ready/valid and the datapath strobes
// ----------------------------
`timescale 1ns/1ps

module aa_ctrl
  import aa_bus_pkg::*;
(
  input  logic    axis_clk,
  input  logic    axis_rst_n,
  input  logic    cc_aa_enable,
  // AXI-Lite slave handshakes
  input  logic    s_awvalid,
  input  logic    s_wvalid,
  input  logic    s_arvalid,
  input  logic    s_rready,
  output logic    s_awready,
  output logic    s_wready,
  output logic    s_arready,
  output logic    s_rvalid,
  // stream slave
  input  logic    as_aa_tvalid,
  input  pkt_e    as_aa_tuser,
  output logic    aa_as_tready,
  // stream master
  input  logic    as_aa_tready,
  output logic    aa_as_tvalid,
  // datapath
  input  logic    ls_local,
  output logic    ls_take,
  output logic    ls_local_wr,
  output logic    rsp_take,
  output logic    ss_addr_take,
  output logic    ss_data_take,
  output tx_sel_e tx_sel
);

  typedef enum logic [3:0] {
    idle,
    ls_wr,
    ls_wr_addr,
    ls_wr_data,
    ls_rd,
    ls_rd_req,
    ls_rd_wait,
    ls_rd_done,
    ss_data
  } ctrl_state_e;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  logic ls_wr_req;
  logic ls_rd_req_in;

  // ----------------------------
  // LS accept, only in idle
  // ----------------------------
  // a pending stream beat wins, the LS side waits
  assign ls_wr_req    = cc_aa_enable & s_awvalid & s_wvalid & ~as_aa_tvalid;
  // writes go first when both are pending
  assign ls_rd_req_in = cc_aa_enable & s_arvalid & ~(s_awvalid & s_wvalid) & ~as_aa_tvalid;

  assign s_awready = (state == idle) & ls_wr_req;
  assign s_wready  = s_awready;
  assign s_arready = (state == idle) & ls_rd_req_in;
  assign ls_take   = s_awready | s_arready;

  // local read answers the cycle after accept
  assign s_rvalid = ((state == ls_rd) & ls_local) | (state == ls_rd_done);

  // ls_local is valid from the cycle after accept
  assign ls_local_wr = (state == ls_wr) & ls_local;

  // ----------------------------
  // stream side
  // ----------------------------
  // slave ready in idle, between SS beats and while waiting for a response
  assign aa_as_tready = (state == idle) | (state == ss_data) | (state == ls_rd_wait);

  assign ss_addr_take = (state == idle) & as_aa_tvalid & (as_aa_tuser == pkt_write);
  assign ss_data_take = (state == ss_data) & as_aa_tvalid;
  assign rsp_take     = (state == ls_rd_wait) & as_aa_tvalid & (as_aa_tuser == pkt_read_rsp);

  // remote beats start in the decision state, no bubble
  always_comb begin
    case (state)
      ls_wr:      tx_sel = ls_local ? tx_none : tx_addr;
      ls_wr_addr: tx_sel = tx_addr;
      ls_wr_data: tx_sel = tx_data;
      ls_rd:      tx_sel = ls_local ? tx_none : tx_rd_req;
      ls_rd_req:  tx_sel = tx_rd_req;
      default:    tx_sel = tx_none;
    endcase
  end

  assign aa_as_tvalid = (tx_sel != tx_none);

  // ----------------------------
  // next state
  // ----------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        // non-write SS beats are swallowed here
        if (ss_addr_take) begin
          state_nxt = ss_data;
        end else if (s_awready) begin
          state_nxt = ls_wr;
        end else if (s_arready) begin
          state_nxt = ls_rd;
        end
      end
      ls_wr: begin
        if (ls_local) begin
          state_nxt = idle;
        end else begin
          state_nxt = as_aa_tready ? ls_wr_data : ls_wr_addr;
        end
      end
      ls_wr_addr: begin
        if (as_aa_tready) begin
          state_nxt = ls_wr_data;
        end
      end
      ls_wr_data: begin
        if (as_aa_tready) begin
          state_nxt = idle;
        end
      end
      ls_rd: begin
        if (ls_local) begin
          state_nxt = s_rready ? idle : ls_rd_done;
        end else begin
          state_nxt = as_aa_tready ? ls_rd_wait : ls_rd_req;
        end
      end
      ls_rd_req: begin
        if (as_aa_tready) begin
          state_nxt = ls_rd_wait;
        end
      end
      // other beat types are accepted and dropped
      ls_rd_wait: begin
        if (rsp_take) begin
          state_nxt = ls_rd_done;
        end
      end
      ls_rd_done: begin
        if (s_rready) begin
          state_nxt = idle;
        end
      end
      ss_data: begin
        if (ss_data_take) begin
          state_nxt = idle;
        end
      end
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------
  // protocol checks
  // ----------------------------
  // write and read paths never accept together
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(s_awready && s_arready));

  // an offered beat is not withdrawn
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid);

endmodule

/* hw/aa_ls_port.sv */
// ----------------------------
// LS port datapath
// latches the AXI-Lite request and the read
// response, decodes local vs remote, muxes
// the outgoing beat and rdata
// ----------------------------
`timescale 1ns/1ps

module aa_ls_port
  import aa_bus_pkg::*;
  import aa_map_pkg::*;
(
  input  logic       axis_clk,
  input  ls_addr_t   s_awaddr,
  input  ls_addr_t   s_araddr,
  input  axis_data_t s_wdata,
  // tells a write accept from a read accept
  input  logic       s_awready,
  input  logic       ls_take,
  input  logic       ls_local_wr,
  input  logic       rsp_take,
  input  axis_beat_t as_aa_beat,
  input  axis_data_t local_rdata,
  input  tx_sel_e    tx_sel,
  output logic       ls_local,
  output reg_wr_t    ls_wr,
  output mbox_idx_t  rd_idx,
  output logic       rd_reg,
  output axis_data_t s_rdata,
  output axis_beat_t aa_as_beat
);

  ls_req_t    req;
  axis_data_t rsp_data;
  ls_region_t region;
  logic       hit_mbox;
  logic       hit_reg;

  // ----------------------------
  // request and response latches
  // ----------------------------
  always_ff @(posedge axis_clk) begin
    if (ls_take) begin
      req.addr  <= s_awready ? s_awaddr : s_araddr;
      req.wdata <= s_wdata;
      req.wr    <= s_awready;
    end
  end

  // data of the pkt_read_rsp beat
  always_ff @(posedge axis_clk) begin
    if (rsp_take) begin
      rsp_data <= as_aa_beat.tdata;
    end
  end

  // ----------------------------
  // region decode
  // ----------------------------
  assign region   = req.addr[ls_region_msb:ls_region_lsb];
  assign hit_mbox = (region == ls_region_mbox);
  assign hit_reg  = (region == ls_region_reg);
  assign ls_local = hit_mbox | hit_reg;

  assign rd_idx = req.addr[mbox_idx_msb:mbox_idx_lsb];
  assign rd_reg = hit_reg;

  // local write port, one cycle strobe from the controller
  assign ls_wr.valid  = ls_local_wr & req.wr;
  assign ls_wr.is_reg = hit_reg;
  assign ls_wr.idx    = rd_idx;
  assign ls_wr.data   = req.wdata;

  // local registers or the remote answer
  assign s_rdata = ls_local ? local_rdata : rsp_data;

  // ----------------------------
  // outgoing beat
  // ----------------------------
  // a remote write goes as address beat then data beat, both pkt_write
  always_comb begin
    case (tx_sel)
      tx_addr: begin
        aa_as_beat.tdata = axis_data_t'(req.addr);
        aa_as_beat.tuser = pkt_write;
      end
      tx_data: begin
        aa_as_beat.tdata = req.wdata;
        aa_as_beat.tuser = pkt_write;
      end
      tx_rd_req: begin
        aa_as_beat.tdata = axis_data_t'(req.addr);
        aa_as_beat.tuser = pkt_read_req;
      end
      default: begin
        aa_as_beat.tdata = '0;
        aa_as_beat.tuser = pkt_stream;
      end
    endcase
  end

endmodule

/* hw/aa_ss_capture.sv */
// ----------------------------
// SS write capture
// holds the address and data beats of a remote
// write and issues one register write for hits
// ----------------------------
`timescale 1ns/1ps

module aa_ss_capture
  import aa_bus_pkg::*;
  import aa_map_pkg::*;
(
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  input  axis_beat_t as_aa_beat,
  input  logic       ss_addr_take,
  input  logic       ss_data_take,
  output reg_wr_t    ss_wr
);

  axis_data_t ss_addr;
  axis_data_t ss_data;
  ss_tag_t    tag;
  logic       have_addr;
  logic       wr_pend;

  // payload latches
  always_ff @(posedge axis_clk) begin
    if (ss_addr_take) begin
      ss_addr <= as_aa_beat.tdata;
    end
    if (ss_data_take) begin
      ss_data <= as_aa_beat.tdata;
    end
  end

  // address seen, then one pending write after the data beat
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      have_addr <= 1'b0;
      wr_pend   <= 1'b0;
    end else begin
      have_addr <= ss_addr_take | (have_addr & ~ss_data_take);
      wr_pend   <= ss_data_take & have_addr;
    end
  end

  // anything outside the bridge is dropped
  assign tag          = ss_addr[ss_tag_msb:ss_tag_lsb];
  assign ss_wr.valid  = wr_pend & ((tag == ss_tag_mbox) | (tag == ss_tag_reg));
  assign ss_wr.is_reg = (tag == ss_tag_reg);
  assign ss_wr.idx    = ss_addr[mbox_idx_msb:mbox_idx_lsb];
  assign ss_wr.data   = ss_data;

  // data beat only ever follows an address beat
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    ss_data_take |-> have_addr);

endmodule

/* hw/aa_mbox_regs.sv */
// ----------------------------
// mailbox and interrupt registers
// eight words, intr_enable, intr_status
// and mb_irq
// ----------------------------
`timescale 1ns/1ps

module aa_mbox_regs
  import aa_bus_pkg::*;
  import aa_map_pkg::*;
(
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  input  reg_wr_t    ls_wr,
  input  reg_wr_t    ss_wr,
  input  mbox_idx_t  rd_idx,
  input  logic       rd_reg,
  output axis_data_t local_rdata,
  output logic       mb_irq
);

  // offset of reg_sel_bit within the word index
  localparam int sel_pos = reg_sel_bit - mbox_idx_lsb;

  axis_data_t mbox [mbox_words];
  logic       intr_enable;
  logic       intr_status;

  logic ls_en_wr;
  logic ls_st_clr;
  logic ss_en_wr;
  logic ss_mb_wr;

  // ----------------------------
  // write decode
  // ----------------------------
  assign ls_en_wr  = ls_wr.valid & ls_wr.is_reg & ~ls_wr.idx[sel_pos];
  // status is write-one-to-clear from LS
  assign ls_st_clr = ls_wr.valid & ls_wr.is_reg & ls_wr.idx[sel_pos] & ls_wr.data[0];
  // SS reaches only the enable register
  assign ss_en_wr  = ss_wr.valid & ss_wr.is_reg & ~ss_wr.idx[sel_pos];
  assign ss_mb_wr  = ss_wr.valid & ~ss_wr.is_reg;

  // mailbox words, either port
  always_ff @(posedge axis_clk) begin
    if (ls_wr.valid & ~ls_wr.is_reg) begin
      mbox[ls_wr.idx] <= ls_wr.data;
    end else if (ss_mb_wr) begin
      mbox[ss_wr.idx] <= ss_wr.data;
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (ls_en_wr) begin
        intr_enable <= ls_wr.data[0];
      end else if (ss_en_wr) begin
        intr_enable <= ss_wr.data[0];
      end
      // a remote mailbox write raises status
      if (ls_st_clr) begin
        intr_status <= 1'b0;
      end else if (ss_mb_wr) begin
        intr_status <= 1'b1;
      end
    end
  end

  // ----------------------------
  // read and interrupt
  // ----------------------------
  always_comb begin
    if (rd_reg) begin
      local_rdata = {{31{1'b0}}, rd_idx[sel_pos] ? intr_status : intr_enable};
    end else begin
      local_rdata = mbox[rd_idx];
    end
  end

  assign mb_irq = intr_status & intr_enable;

  // the FSM keeps LS and SS writes apart
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ls_wr.valid && ss_wr.valid));

endmodule

/* hw/aa_bridge_top.sv */
// ----------------------------
// AXI-Lite to AXI-Stream mailbox bridge
// controller, LS port, SS capture and registers
// ----------------------------
`timescale 1ns/1ps

module aa_bridge_top
  import aa_bus_pkg::*;
  import aa_map_pkg::*;
(
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  input  logic       cc_aa_enable,
  // LS AW, W, AR, R
  output logic       s_awready,
  input  logic       s_awvalid,
  input  ls_addr_t   s_awaddr,
  output logic       s_wready,
  input  logic       s_wvalid,
  input  axis_data_t s_wdata,
  output logic       s_arready,
  input  logic       s_arvalid,
  input  ls_addr_t   s_araddr,
  output axis_data_t s_rdata,
  output logic       s_rvalid,
  input  logic       s_rready,
  // stream slave
  input  axis_beat_t as_aa_beat,
  input  logic       as_aa_tvalid,
  output logic       aa_as_tready,
  // stream master
  output axis_beat_t aa_as_beat,
  output logic       aa_as_tvalid,
  input  logic       as_aa_tready,
  output logic       mb_irq
);

  logic       ls_local;
  logic       ls_take;
  logic       ls_local_wr;
  logic       rsp_take;
  logic       ss_addr_take;
  logic       ss_data_take;
  tx_sel_e    tx_sel;
  reg_wr_t    ls_wr;
  reg_wr_t    ss_wr;
  mbox_idx_t  rd_idx;
  logic       rd_reg;
  axis_data_t local_rdata;

  aa_ctrl u_ctrl (
    .axis_clk     (axis_clk),
    .axis_rst_n   (axis_rst_n),
    .cc_aa_enable (cc_aa_enable),
    .s_awvalid    (s_awvalid),
    .s_wvalid     (s_wvalid),
    .s_arvalid    (s_arvalid),
    .s_rready     (s_rready),
    .s_awready    (s_awready),
    .s_wready     (s_wready),
    .s_arready    (s_arready),
    .s_rvalid     (s_rvalid),
    .as_aa_tvalid (as_aa_tvalid),
    .as_aa_tuser  (as_aa_beat.tuser),
    .aa_as_tready (aa_as_tready),
    .as_aa_tready (as_aa_tready),
    .aa_as_tvalid (aa_as_tvalid),
    .ls_local     (ls_local),
    .ls_take      (ls_take),
    .ls_local_wr  (ls_local_wr),
    .rsp_take     (rsp_take),
    .ss_addr_take (ss_addr_take),
    .ss_data_take (ss_data_take),
    .tx_sel       (tx_sel)
  );

  aa_ls_port u_ls_port (
    .axis_clk    (axis_clk),
    .s_awaddr    (s_awaddr),
    .s_araddr    (s_araddr),
    .s_wdata     (s_wdata),
    .s_awready   (s_awready),
    .ls_take     (ls_take),
    .ls_local_wr (ls_local_wr),
    .rsp_take    (rsp_take),
    .as_aa_beat  (as_aa_beat),
    .local_rdata (local_rdata),
    .tx_sel      (tx_sel),
    .ls_local    (ls_local),
    .ls_wr       (ls_wr),
    .rd_idx      (rd_idx),
    .rd_reg      (rd_reg),
    .s_rdata     (s_rdata),
    .aa_as_beat  (aa_as_beat)
  );

  aa_ss_capture u_ss_capture (
    .axis_clk     (axis_clk),
    .axis_rst_n   (axis_rst_n),
    .as_aa_beat   (as_aa_beat),
    .ss_addr_take (ss_addr_take),
    .ss_data_take (ss_data_take),
    .ss_wr        (ss_wr)
  );

  aa_mbox_regs u_mbox_regs (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .ls_wr       (ls_wr),
    .ss_wr       (ss_wr),
    .rd_idx      (rd_idx),
    .rd_reg      (rd_reg),
    .local_rdata (local_rdata),
    .mb_irq      (mb_irq)
  );

endmodule

/* tests/aa_clk_gen.sv */
// ----------------------------
// testbench clock and reset
// 8 ns clock, reset low for 10 cycles
// ----------------------------
`timescale 1ns/1ps

module aa_clk_gen (
  output logic axis_clk,
  output logic axis_rst_n
);

  localparam int half_ns      = 4;
  localparam int reset_cycles = 10;

  initial begin
    axis_clk = 1'b0;
    forever #half_ns axis_clk = ~axis_clk;
  end

  // release 1 ns after an edge, like every other input
  initial begin
    axis_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge axis_clk);
    #1;
    axis_rst_n = 1'b1;
  end

endmodule

/* tests/aa_tb.sv */
// ----------------------------
// mailbox bridge testbench
// drives LS and both stream sides, checks
// against a mailbox and interrupt model
// ----------------------------
`timescale 1ns/1ps

module aa_tb
  import aa_bus_pkg::*;
  import aa_map_pkg::*;
();

  // ----------------------------
  // run length and watchdog
  // ----------------------------
  localparam int clk_period_ns = 8;
  localparam int len_reset     = 20;
  localparam int len_mbox      = 200;
  localparam int len_remote_wr = 60;
  localparam int len_remote_rd = 60;
  localparam int len_irq       = 150;
  localparam int len_enable    = 60;
  localparam int watchdog_ns   = (len_reset + len_mbox + len_remote_wr + len_remote_rd
                                  + len_irq + len_enable) * 4 * clk_period_ns;

  logic       axis_clk;
  logic       axis_rst_n;
  logic       cc_aa_enable;
  logic       s_awready, s_awvalid, s_wready, s_wvalid;
  logic       s_arready, s_arvalid, s_rvalid, s_rready;
  ls_addr_t   s_awaddr, s_araddr;
  axis_data_t s_wdata, s_rdata;
  axis_beat_t as_aa_beat, aa_as_beat;
  logic       as_aa_tvalid, aa_as_tready, aa_as_tvalid, as_aa_tready;
  logic       mb_irq;

  logic [31:0] lfsr = 32'hf17e6436;
  logic        random_ready;
  axis_beat_t  tx_q[$];
  int          tx_count;
  int          errors, test_num, tests_failed, test_err_base;
  string       test_name;
  // reference model of the register block
  axis_data_t  mbox_model [8];

  aa_clk_gen u_clk_gen (.axis_clk(axis_clk), .axis_rst_n(axis_rst_n));

  aa_bridge_top dut (.*);

  // one Galois step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge axis_clk);
    #1;
  endtask

  task automatic begin_test(string name);
    test_num++;
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_base) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, test_name, errors - test_err_base);
      tests_failed++;
    end
  endtask

  // ----------------------------
  // bus drivers
  // ----------------------------
  task automatic ls_write(ls_addr_t addr, axis_data_t data);
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    do @(negedge axis_clk); while (!s_awready);
    // W is taken together with AW
    check_eq("s_wready", s_wready, 1'b1);
    next_cycle();
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
  endtask

  // rready held low a random number of cycles to test rdata hold
  task automatic ls_read(ls_addr_t addr, output axis_data_t data);
    int hold;
    hold      = take_bits(2);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    do @(negedge axis_clk); while (!s_arready);
    next_cycle();
    s_arvalid = 1'b0;
    do @(negedge axis_clk); while (!s_rvalid);
    next_cycle();
    repeat (hold) next_cycle();
    s_rready = 1'b1;
    @(negedge axis_clk);
    check_eq("s_rvalid", s_rvalid, 1'b1);
    data = s_rdata;
    next_cycle();
    s_rready = 1'b0;
  endtask

  task automatic ss_send(axis_data_t data, pkt_e tuser);
    as_aa_beat.tdata = data;
    as_aa_beat.tuser = tuser;
    as_aa_tvalid     = 1'b1;
    do @(negedge axis_clk); while (!aa_as_tready);
    next_cycle();
    as_aa_tvalid = 1'b0;
  endtask

  // stream master ready, random only while a test asks for it
  always @(posedge axis_clk) begin
    #1;
    if (random_ready) begin
      as_aa_tready = take_bits(1) == 32'd1;
    end else begin
      as_aa_tready = 1'b1;
    end
  end

  // beats leaving the bridge, sampled mid cycle
  always @(negedge axis_clk) begin
    if (aa_as_tvalid && as_aa_tready) begin
      tx_q.push_back(aa_as_beat);
      tx_count++;
    end
  end

  // ----------------------------
  // protocol checks
  // ----------------------------
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as_beat))
  else begin
    $display("ERROR aa_as_beat dropped or changed while tready low, now %h", aa_as_beat);
    errors++;
  end

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
  else begin
    $display("ERROR s_rdata dropped or changed while rready low, now %h", s_rdata);
    errors++;
  end

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !cc_aa_enable |-> !s_awready && !s_arready)
  else begin
    $display("LS request accepted while cc_aa_enable was low");
    errors++;
  end

  initial begin
    #watchdog_ns;
    $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

  // ----------------------------
  // test sequence
  // ----------------------------
  initial begin
    ls_addr_t   addr;
    axis_data_t data, rdata;
    mbox_idx_t  idx;
    int         base;
    cc_aa_enable = 1'b1;
    s_awvalid    = 1'b0;
    s_wvalid     = 1'b0;
    s_arvalid    = 1'b0;
    s_rready     = 1'b0;
    s_awaddr     = '0;
    s_araddr     = '0;
    s_wdata      = '0;
    as_aa_beat   = '0;
    as_aa_tvalid = 1'b0;
    as_aa_tready = 1'b1;
    random_ready = 1'b0;
    @(posedge axis_rst_n);
    next_cycle();

    begin_test("reset state");
    check_eq("s_rvalid", s_rvalid, 1'b0);
    check_eq("aa_as_tvalid", aa_as_tvalid, 1'b0);
    check_eq("mb_irq", mb_irq, 1'b0);
    end_test();

    begin_test("mailbox write and read back");
    base = tx_count;
    for (int i = 0; i < 8; i++) begin
      mbox_model[i] = take_bits(32);
      ls_write(ls_addr_t'(i << 2), mbox_model[i]);
    end
    for (int i = 0; i < 8; i++) begin
      ls_read(ls_addr_t'(i << 2), rdata);
      check_eq("s_rdata", rdata, mbox_model[i]);
    end
    check_eq("stream beat count", tx_count, base);
    end_test();

    begin_test("remote write");
    // region 4'ha lies outside the bridge
    addr = {3'(take_bits(3)), 4'ha, 8'(take_bits(8))};
    data = take_bits(32);
    base = tx_count;
    random_ready = 1'b1;
    ls_write(addr, data);
    wait (tx_count == base + 2);
    random_ready = 1'b0;
    repeat (4) next_cycle();
    check_eq("stream beat count", tx_count, base + 2);
    check_eq("aa_as_beat.tdata", tx_q[base].tdata, {17'h0, addr});
    check_eq("aa_as_beat.tuser", tx_q[base].tuser, pkt_write);
    check_eq("aa_as_beat.tdata", tx_q[base + 1].tdata, data);
    check_eq("aa_as_beat.tuser", tx_q[base + 1].tuser, pkt_write);
    end_test();

    begin_test("remote read");
    addr = {3'(take_bits(3)), 4'h3, 8'(take_bits(8))};
    data = take_bits(32);
    base = tx_count;
    fork
      ls_read(addr, rdata);
      begin
        wait (tx_count == base + 1);
        next_cycle();
        // unrelated beat during the wait is dropped
        ss_send(~data, pkt_stream);
        ss_send(data, pkt_read_rsp);
      end
    join
    check_eq("s_rdata", rdata, data);
    check_eq("stream beat count", tx_count, base + 1);
    check_eq("aa_as_beat.tdata", tx_q[base].tdata, {17'h0, addr});
    check_eq("aa_as_beat.tuser", tx_q[base].tuser, pkt_read_req);
    end_test();

    begin_test("interrupt sequence");
    ls_write(15'h0100, 32'h1);
    idx  = take_bits(3);
    data = take_bits(32);
    ss_send({4'h0, ss_tag_mbox, 3'b0, idx, 2'b00}, pkt_write);
    ss_send(data, pkt_write);
    mbox_model[idx] = data;
    repeat (2) next_cycle();
    check_eq("mb_irq", mb_irq, 1'b1);
    ls_read(ls_addr_t'(idx << 2), rdata);
    check_eq("s_rdata", rdata, mbox_model[idx]);
    // write one to clear status
    ls_write(15'h0104, 32'h1);
    repeat (2) next_cycle();
    check_eq("mb_irq", mb_irq, 1'b0);
    // tag outside the bridge, no register changes
    ss_send({4'h0, 20'h00500, 3'b0, idx, 2'b00}, pkt_write);
    ss_send(~data, pkt_write);
    repeat (2) next_cycle();
    check_eq("mb_irq", mb_irq, 1'b0);
    ls_read(ls_addr_t'(idx << 2), rdata);
    check_eq("s_rdata", rdata, mbox_model[idx]);
    end_test();

    begin_test("enable gating");
    idx  = take_bits(3);
    data = take_bits(32);
    cc_aa_enable = 1'b0;
    fork
      ls_write(ls_addr_t'(idx << 2), data);
      ls_read(ls_addr_t'(idx << 2), rdata);
      begin
        repeat (6) begin
          @(negedge axis_clk);
          check_eq("s_awready", s_awready, 1'b0);
          check_eq("s_arready", s_arready, 1'b0);
        end
        next_cycle();
        cc_aa_enable = 1'b1;
      end
    join
    // write is accepted first, so the read sees the new word
    mbox_model[idx] = data;
    check_eq("s_rdata", rdata, mbox_model[idx]);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/aa_map_pkg.sv
hw/aa_bus_pkg.sv
hw/aa_ctrl.sv
hw/aa_ls_port.sv
hw/aa_ss_capture.sv
hw/aa_mbox_regs.sv
hw/aa_bridge_top.sv
tests/aa_clk_gen.sv
tests/aa_tb.sv

/* Bender.yml */
package:
  name: aa_mbox_bridge

sources:
  # packages first, the bus package imports the map package
  - hw/aa_map_pkg.sv
  - hw/aa_bus_pkg.sv
  - hw/aa_ctrl.sv
  - hw/aa_ls_port.sv
  - hw/aa_ss_capture.sv
  - hw/aa_mbox_regs.sv
  - hw/aa_bridge_top.sv
  - target: test
    files:
      - tests/aa_clk_gen.sv
      - tests/aa_tb.sv
